// File: verilog/legIsaPkg.sv
package legIsaPkg;

  // datapath widths
  localparam int instrWidth = 32;
  localparam int dataWidth = 64;
  localparam int regIdxWidth = 5;

  // opcode field start bits
  localparam int opc11Lsb = 21;
  localparam int opc10Lsb = 22;

  // operand field positions
  localparam int rmLsb = 16;
  localparam int shamtLsb = 10;
  localparam int shamtWidth = 6;
  localparam int immLsb = 10;
  localparam int immWidth = 12;
  localparam int rnLsb = 5;
  localparam int rdLsb = 0;

  // reads as zero, writes dropped
  localparam logic [regIdxWidth-1:0] zeroReg = 5'd31;

  // pc always steps one word
  localparam logic [dataWidth-1:0] pcStep = 64'd4;

  // register forms and shifts, bits 31..21
  localparam logic [instrWidth-opc11Lsb-1:0] encAdd = 11'b10001011000;
  localparam logic [instrWidth-opc11Lsb-1:0] encAdds = 11'b10101011000;
  localparam logic [instrWidth-opc11Lsb-1:0] encSub = 11'b11001011000;
  localparam logic [instrWidth-opc11Lsb-1:0] encSubs = 11'b11101011000;
  localparam logic [instrWidth-opc11Lsb-1:0] encAnd = 11'b10001010000;
  localparam logic [instrWidth-opc11Lsb-1:0] encAnds = 11'b11101010000;
  localparam logic [instrWidth-opc11Lsb-1:0] encOrr = 11'b10101010000;
  localparam logic [instrWidth-opc11Lsb-1:0] encEor = 11'b11001010000;
  localparam logic [instrWidth-opc11Lsb-1:0] encLsl = 11'b11010011011;
  localparam logic [instrWidth-opc11Lsb-1:0] encLsr = 11'b11010011010;

  // immediate forms, bits 31..22
  localparam logic [instrWidth-opc10Lsb-1:0] encAddi = 10'b1001000100;
  localparam logic [instrWidth-opc10Lsb-1:0] encAddis = 10'b1011000100;
  localparam logic [instrWidth-opc10Lsb-1:0] encSubi = 10'b1101000100;
  localparam logic [instrWidth-opc10Lsb-1:0] encSubis = 10'b1111000100;
  localparam logic [instrWidth-opc10Lsb-1:0] encAndi = 10'b1001001000;
  localparam logic [instrWidth-opc10Lsb-1:0] encAndis = 10'b1111001000;
  localparam logic [instrWidth-opc10Lsb-1:0] encOrri = 10'b1011001000;
  localparam logic [instrWidth-opc10Lsb-1:0] encEori = 10'b1101001000;

endpackage

// File: verilog/legCorePkg.sv
package legCorePkg;

  // alu operation selected by decode
  typedef enum logic [2:0] {
    opAdd,
    opSub,
    opAnd,
    opOrr,
    opEor,
    opLsl,
    opLsr
  } aluOp;

  // one decoded instruction as it moves down the pipe
  typedef struct packed {
    aluOp op;
    logic setFlags;
    logic useImm;
    logic [legIsaPkg::regIdxWidth-1:0] rd;
    logic [legIsaPkg::regIdxWidth-1:0] rn;
    logic [legIsaPkg::regIdxWidth-1:0] rm;
    logic [legIsaPkg::immWidth-1:0] imm;
    logic [legIsaPkg::shamtWidth-1:0] shamt;
  } decodedInstr;

  // n is the msb when packed into four bits
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagSet;

  // queue sizing, depth kept a power of two
  localparam int queueDepth = 4;
  localparam int qPtrWidth = $clog2(queueDepth);
  localparam int qCountWidth = $clog2(queueDepth + 1);
  localparam logic [qCountWidth-1:0] queueFull = qCountWidth'(queueDepth);

endpackage

// File: verilog/instrLink.sv
`timescale 1ns/1ns

interface instrLink;

  // four-phase request and acknowledge
  logic req;
  logic ack;

  // held stable by the source while req is high
  legCorePkg::decodedInstr payload;

  // producer side
  modport source (
    output req,
    output payload,
    input ack
  );

  // consumer side
  modport sink (
    input req,
    input payload,
    output ack
  );

endinterface

// File: verilog/fetchDecode.sv
`timescale 1ns/1ns

module fetchDecode (
  input  logic                                 clk,
  input  logic                                 rstN,
  output logic [legIsaPkg::dataWidth-1:0]      iaddr,
  input  logic [legIsaPkg::instrWidth-1:0]     ibus,
  instrLink.source                             fetchLink
);

  typedef enum logic [1:0] {
    idle,
    request,
    waitAckLow
  } fetchState;

  fetchState state;
  legCorePkg::decodedInstr dec;
  legCorePkg::decodedInstr payloadReg;
  logic [legIsaPkg::instrWidth-legIsaPkg::opc11Lsb-1:0] opc11;
  logic [legIsaPkg::instrWidth-legIsaPkg::opc10Lsb-1:0] opc10;
  logic hit11;
  logic hit10;
  logic valid;

  assign opc11 = ibus[legIsaPkg::instrWidth-1:legIsaPkg::opc11Lsb];
  assign opc10 = ibus[legIsaPkg::instrWidth-1:legIsaPkg::opc10Lsb];

  // decode the word on ibus
  always_comb begin
    dec = '0;
    hit11 = 1'b1;
    hit10 = 1'b1;
    dec.rd = ibus[legIsaPkg::rdLsb +: legIsaPkg::regIdxWidth];
    dec.rn = ibus[legIsaPkg::rnLsb +: legIsaPkg::regIdxWidth];
    dec.rm = ibus[legIsaPkg::rmLsb +: legIsaPkg::regIdxWidth];
    dec.imm = ibus[legIsaPkg::immLsb +: legIsaPkg::immWidth];
    dec.shamt = ibus[legIsaPkg::shamtLsb +: legIsaPkg::shamtWidth];
    // register forms first
    case (opc11)
      legIsaPkg::encAdd, legIsaPkg::encAdds: dec.op = legCorePkg::opAdd;
      legIsaPkg::encSub, legIsaPkg::encSubs: dec.op = legCorePkg::opSub;
      legIsaPkg::encAnd, legIsaPkg::encAnds: dec.op = legCorePkg::opAnd;
      legIsaPkg::encOrr: dec.op = legCorePkg::opOrr;
      legIsaPkg::encEor: dec.op = legCorePkg::opEor;
      legIsaPkg::encLsl: dec.op = legCorePkg::opLsl;
      legIsaPkg::encLsr: dec.op = legCorePkg::opLsr;
      default: hit11 = 1'b0;
    endcase
    // then immediates
    if (!hit11) begin
      case (opc10)
        legIsaPkg::encAddi, legIsaPkg::encAddis: dec.op = legCorePkg::opAdd;
        legIsaPkg::encSubi, legIsaPkg::encSubis: dec.op = legCorePkg::opSub;
        legIsaPkg::encAndi, legIsaPkg::encAndis: dec.op = legCorePkg::opAnd;
        legIsaPkg::encOrri: dec.op = legCorePkg::opOrr;
        legIsaPkg::encEori: dec.op = legCorePkg::opEor;
        default: hit10 = 1'b0;
      endcase
    end
    dec.useImm = !hit11;
    if (hit11) begin
      dec.setFlags = opc11 inside {legIsaPkg::encAdds, legIsaPkg::encSubs, legIsaPkg::encAnds};
    end else begin
      dec.setFlags = opc10 inside {legIsaPkg::encAddis, legIsaPkg::encSubis,
                                   legIsaPkg::encAndis};
    end
    // nop and anything unknown falls out here
    valid = hit11 || hit10;
  end

  // pc and producer handshake
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
      iaddr <= '0;
    end else begin
      case (state)
        idle: begin
          // sample and step in the same edge
          iaddr <= iaddr + legIsaPkg::pcStep;
          if (valid) state <= request;
        end
        request: if (fetchLink.ack) state <= waitAckLow;
        waitAckLow: if (!fetchLink.ack) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // latch decoded word for the link
  always_ff @(posedge clk) begin
    if (state == idle && valid) payloadReg <= dec;
  end

  assign fetchLink.req = (state == request);
  assign fetchLink.payload = payloadReg;

endmodule

// File: verilog/instrQueue.sv
`timescale 1ns/1ns

module instrQueue (
  input  logic       clk,
  input  logic       rstN,
  instrLink.sink     fetchLink,
  instrLink.source   issueLink
);

  typedef enum logic {
    sinkIdle,
    sinkAck
  } sinkState;

  typedef enum logic [1:0] {
    srcIdle,
    srcReq,
    srcWaitAckLow
  } srcState;

  sinkState inState;
  srcState outState;
  legCorePkg::decodedInstr mem [legCorePkg::queueDepth];
  logic [legCorePkg::qPtrWidth-1:0] wrPtr;
  logic [legCorePkg::qPtrWidth-1:0] rdPtr;
  logic [legCorePkg::qCountWidth-1:0] count;
  logic push;
  logic pop;

  // take a word only with room left
  assign push = (inState == sinkIdle) && fetchLink.req && (count != legCorePkg::queueFull);
  // entry leaves once the consumer acks
  assign pop = (outState == srcReq) && issueLink.ack;

  // entry storage
  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= fetchLink.payload;
  end

  // pointers wrap on their own
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;
      if (pop) rdPtr <= rdPtr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // sink side
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inState <= sinkIdle;
    end else begin
      case (inState)
        sinkIdle: if (push) inState <= sinkAck;
        sinkAck: if (!fetchLink.req) inState <= sinkIdle;
        default: inState <= sinkIdle;
      endcase
    end
  end

  // source side, runs alongside the sink
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outState <= srcIdle;
    end else begin
      case (outState)
        srcIdle: if (count != '0) outState <= srcReq;
        srcReq: if (issueLink.ack) outState <= srcWaitAckLow;
        srcWaitAckLow: if (!issueLink.ack) outState <= srcIdle;
        default: outState <= srcIdle;
      endcase
    end
  end

  assign fetchLink.ack = (inState == sinkAck);
  assign issueLink.req = (outState == srcReq);
  // oldest entry, steady while req is up
  assign issueLink.payload = mem[rdPtr];

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic [legIsaPkg::regIdxWidth-1:0]  rdAddrA,
  input  logic [legIsaPkg::regIdxWidth-1:0]  rdAddrB,
  output logic [legIsaPkg::dataWidth-1:0]    rdDataA,
  output logic [legIsaPkg::dataWidth-1:0]    rdDataB,
  input  logic                               wrEn,
  input  logic [legIsaPkg::regIdxWidth-1:0]  wrAddr,
  input  logic [legIsaPkg::dataWidth-1:0]    wrData
);

  // x0..x30, x31 has no storage
  logic [legIsaPkg::dataWidth-1:0] regs [0:legIsaPkg::zeroReg-1];

  // async reads
  assign rdDataA = (rdAddrA == legIsaPkg::zeroReg) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == legIsaPkg::zeroReg) ? '0 : regs[rdAddrB];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wrEn && wrAddr != legIsaPkg::zeroReg) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
  input  logic                               clk,
  input  logic                               rstN,
  instrLink.sink                             issueLink,
  output logic                               retireReq,
  input  logic                               retireAck,
  output logic [legIsaPkg::regIdxWidth-1:0]  retireRd,
  output logic [legIsaPkg::dataWidth-1:0]    retireData,
  output legCorePkg::flagSet                 retireFlags
);

  typedef enum logic [1:0] {
    exIdle,
    exRetire,
    exWaitAckLow
  } exState;

  exState state;
  legCorePkg::decodedInstr ins;
  legCorePkg::flagSet flags;
  legCorePkg::flagSet nextFlags;
  logic issueAck;
  logic accept;
  logic [legIsaPkg::dataWidth-1:0] opA;
  logic [legIsaPkg::dataWidth-1:0] regB;
  logic [legIsaPkg::dataWidth-1:0] opB;
  logic [legIsaPkg::dataWidth-1:0] addB;
  logic [legIsaPkg::dataWidth:0] addFull;
  logic [legIsaPkg::dataWidth-1:0] result;
  logic isSub;

  assign ins = issueLink.payload;

  regFile i_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (ins.rn),
    .rdAddrB (ins.rm),
    .rdDataA (opA),
    .rdDataB (regB),
    .wrEn    (accept),
    .wrAddr  (ins.rd),
    .wrData  (result)
  );

  // new issue only when both handshakes are done
  assign accept = (state == exIdle) && issueLink.req && !issueAck;

  // second operand, imm is zero extended
  assign opB = ins.useImm ?
               {{(legIsaPkg::dataWidth-legIsaPkg::immWidth){1'b0}}, ins.imm} : regB;

  // subtract as a + ~b + 1
  assign isSub = (ins.op == legCorePkg::opSub);
  assign addB = isSub ? ~opB : opB;
  assign addFull = {1'b0, opA} + {1'b0, addB} + {{legIsaPkg::dataWidth{1'b0}}, isSub};

  always_comb begin
    case (ins.op)
      legCorePkg::opAdd, legCorePkg::opSub: result = addFull[legIsaPkg::dataWidth-1:0];
      legCorePkg::opAnd: result = opA & opB;
      legCorePkg::opOrr: result = opA | opB;
      legCorePkg::opEor: result = opA ^ opB;
      legCorePkg::opLsl: result = opA << ins.shamt;
      legCorePkg::opLsr: result = opA >> ins.shamt;
      default: result = '0;
    endcase
  end

  always_comb begin
    nextFlags.n = result[legIsaPkg::dataWidth-1];
    nextFlags.z = (result == '0);
    // carry and overflow from the adder
    nextFlags.c = addFull[legIsaPkg::dataWidth];
    nextFlags.v = (opA[legIsaPkg::dataWidth-1] == addB[legIsaPkg::dataWidth-1]) &&
                  (result[legIsaPkg::dataWidth-1] != opA[legIsaPkg::dataWidth-1]);
    // logic forms clear c and v
    if (ins.op == legCorePkg::opAnd) begin
      nextFlags.c = 1'b0;
      nextFlags.v = 1'b0;
    end
  end

  // control, flags and issue ack
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= exIdle;
      flags <= '0;
      issueAck <= 1'b0;
    end else begin
      if (accept) issueAck <= 1'b1;
      else if (!issueLink.req) issueAck <= 1'b0;
      if (accept && ins.setFlags) flags <= nextFlags;
      case (state)
        exIdle: if (accept) state <= exRetire;
        exRetire: if (retireAck) state <= exWaitAckLow;
        exWaitAckLow: if (!retireAck) state <= exIdle;
        default: state <= exIdle;
      endcase
    end
  end

  // retire values held through the handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      retireRd <= ins.rd;
      retireData <= result;
    end
  end

  assign issueLink.ack = issueAck;
  assign retireReq = (state == exRetire);
  assign retireFlags = flags;

endmodule

// File: verilog/legCore.sv
`timescale 1ns/1ns

module legCore (
  input  logic                               clk,
  input  logic                               rstN,
  output logic [legIsaPkg::dataWidth-1:0]    iaddr,
  input  logic [legIsaPkg::instrWidth-1:0]   ibus,
  output logic                               retireReq,
  input  logic                               retireAck,
  output logic [legIsaPkg::regIdxWidth-1:0]  retireRd,
  output logic [legIsaPkg::dataWidth-1:0]    retireData,
  output logic [3:0]                         retireFlags
);

  // fetch to queue, queue to execute
  instrLink fetchLink ();
  instrLink issueLink ();

  fetchDecode i_fetchDecode (
    .clk       (clk),
    .rstN      (rstN),
    .iaddr     (iaddr),
    .ibus      (ibus),
    .fetchLink (fetchLink.source)
  );

  instrQueue i_instrQueue (
    .clk       (clk),
    .rstN      (rstN),
    .fetchLink (fetchLink.sink),
    .issueLink (issueLink.source)
  );

  // flags leave as {n, z, c, v}
  executeUnit i_executeUnit (
    .clk         (clk),
    .rstN        (rstN),
    .issueLink   (issueLink.sink),
    .retireReq   (retireReq),
    .retireAck   (retireAck),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .retireFlags (retireFlags)
  );

endmodule

// File: bench/legCoreTb.sv
`timescale 1ns/1ns

module legCoreTb;

  localparam int xlen = legIsaPkg::dataWidth;
  localparam int ilen = legIsaPkg::instrWidth;
  localparam int progWords = 64;
  localparam int directedWords = 8;
  localparam int waitLimit = 400;
  localparam int runLimit = 20000;
  localparam int stallCycles = 60;
  localparam int stallWindow = 20;
  localparam int drainCycles = 30;
  localparam logic [31:0] lcgSeed = 32'h1e40b5e8;
  localparam logic [4:0] zr = legIsaPkg::zeroReg;

  // opcode tables for random program words
  localparam logic [10:0] rEncs [10] = '{legIsaPkg::encAdd, legIsaPkg::encAdds,
    legIsaPkg::encSub, legIsaPkg::encSubs, legIsaPkg::encAnd, legIsaPkg::encAnds,
    legIsaPkg::encOrr, legIsaPkg::encEor, legIsaPkg::encLsl, legIsaPkg::encLsr};
  localparam logic [9:0] iEncs [8] = '{legIsaPkg::encAddi, legIsaPkg::encAddis,
    legIsaPkg::encSubi, legIsaPkg::encSubis, legIsaPkg::encAndi, legIsaPkg::encAndis,
    legIsaPkg::encOrri, legIsaPkg::encEori};

  logic clk;
  logic rstN;
  logic [xlen-1:0] iaddr;
  logic [ilen-1:0] ibus;
  logic retireReq;
  logic retireAck;
  logic [4:0] retireRd;
  logic [xlen-1:0] retireData;
  logic [3:0] retireFlags;

  logic [ilen-1:0] progMem [progWords];
  logic [31:0] lcgState;
  logic [4:0] expRd [$];
  logic [xlen-1:0] expData [$];
  logic [3:0] expFlags [$];
  int expCount = 0;
  int retireCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  logic hung = 1'b0;
  logic prevReq = 1'b0;
  logic [3:0] prevFlags = '0;
  logic [xlen-1:0] lastIaddr = '0;

  legCore i_legCore (
    .clk         (clk),
    .rstN        (rstN),
    .iaddr       (iaddr),
    .ibus        (ibus),
    .retireReq   (retireReq),
    .retireAck   (retireAck),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .retireFlags (retireFlags)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [ilen-1:0] rForm(input logic [10:0] opc, input logic [4:0] rd,
                                            input logic [4:0] rn, input logic [4:0] rm,
                                            input logic [5:0] shamt);
    return {opc, rm, shamt, rn, rd};
  endfunction

  function automatic logic [ilen-1:0] iForm(input logic [9:0] opc, input logic [4:0] rd,
                                            input logic [4:0] rn, input logic [11:0] imm);
    return {opc, imm, rn, rd};
  endfunction

  // kept encodings mostly, some zero words and raw random words
  function automatic logic [ilen-1:0] randomWord();
    logic [31:0] sel;
    logic [31:0] f;
    logic [4:0] pick;
    logic [5:0] shamt;
    sel = lcgNext();
    f = lcgNext();
    pick = sel[31:27];
    // only the two shift encodings carry a shift amount
    shamt = (pick >= 5'd8) ? f[16:11] : 6'd0;
    if (pick < 5'd10)
      return rForm(rEncs[pick[3:0]], f[31:27], f[26:22], f[21:17], shamt);
    else if (pick < 5'd26)
      return iForm(iEncs[pick[2:0]], f[31:27], f[26:22], f[16:5]);
    else if (pick < 5'd29)
      return '0;
    else
      return f;
  endfunction

  // word beyond the program reads as nop
  function automatic logic [ilen-1:0] fetchWord(input logic [xlen-1:0] addr);
    if (addr < 64'(4 * progWords))
      return progMem[addr[7:2]];
    else
      return '0;
  endfunction

  // architectural model of one word, returns whether it retires
  function automatic logic refExec(
    input  logic [ilen-1:0] word,
    input  logic [xlen-1:0] regsIn [32],
    input  logic [3:0]      flagsIn,
    output logic [4:0]      rdOut,
    output logic [xlen-1:0] dataOut,
    output logic [3:0]      flagsOut
  );
    logic [4:0] rn;
    logic [4:0] rm;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen:0] sum;
    logic c;
    logic v;
    logic sets;
    int op;
    rdOut = word[legIsaPkg::rdLsb +: 5];
    rn = word[legIsaPkg::rnLsb +: 5];
    rm = word[legIsaPkg::rmLsb +: 5];
    a = (rn == zr) ? '0 : regsIn[rn];
    b = (rm == zr) ? '0 : regsIn[rm];
    c = 1'b0;
    v = 1'b0;
    op = -1;
    // 0 add, 1 sub, 2 and, 3 orr, 4 eor, 5 lsl, 6 lsr
    case (word[31:21])
      legIsaPkg::encAdd, legIsaPkg::encAdds: op = 0;
      legIsaPkg::encSub, legIsaPkg::encSubs: op = 1;
      legIsaPkg::encAnd, legIsaPkg::encAnds: op = 2;
      legIsaPkg::encOrr: op = 3;
      legIsaPkg::encEor: op = 4;
      legIsaPkg::encLsl: op = 5;
      legIsaPkg::encLsr: op = 6;
      default: op = -1;
    endcase
    sets = word[31:21] inside {legIsaPkg::encAdds, legIsaPkg::encSubs, legIsaPkg::encAnds};
    if (op < 0) begin
      b = {{(xlen-12){1'b0}}, word[legIsaPkg::immLsb +: 12]};
      case (word[31:22])
        legIsaPkg::encAddi, legIsaPkg::encAddis: op = 0;
        legIsaPkg::encSubi, legIsaPkg::encSubis: op = 1;
        legIsaPkg::encAndi, legIsaPkg::encAndis: op = 2;
        legIsaPkg::encOrri: op = 3;
        legIsaPkg::encEori: op = 4;
        default: op = -1;
      endcase
      sets = word[31:22] inside {legIsaPkg::encAddis, legIsaPkg::encSubis,
                                 legIsaPkg::encAndis};
    end
    case (op)
      0: begin
        sum = {1'b0, a} + {1'b0, b};
        dataOut = sum[xlen-1:0];
        c = sum[xlen];
        v = (a[xlen-1] == b[xlen-1]) && (dataOut[xlen-1] != a[xlen-1]);
      end
      1: begin
        dataOut = a - b;
        // carry set when nothing is borrowed
        c = (a >= b);
        v = (a[xlen-1] != b[xlen-1]) && (dataOut[xlen-1] != a[xlen-1]);
      end
      2: dataOut = a & b;
      3: dataOut = a | b;
      4: dataOut = a ^ b;
      5: dataOut = a << word[legIsaPkg::shamtLsb +: 6];
      6: dataOut = a >> word[legIsaPkg::shamtLsb +: 6];
      default: dataOut = '0;
    endcase
    flagsOut = sets ? {dataOut[xlen-1], dataOut == '0, c, v} : flagsIn;
    return op >= 0;
  endfunction

  task automatic buildProgram();
    // directed head, all recognized so the stall fills the queue
    progMem[0] = iForm(legIsaPkg::encAddi, 5'd6, zr, 12'd10);
    // negative result
    progMem[1] = iForm(legIsaPkg::encSubis, 5'd2, zr, 12'd5);
    // zero result
    progMem[2] = iForm(legIsaPkg::encAddis, 5'd3, zr, 12'd0);
    // -5 + 10 carries out
    progMem[3] = rForm(legIsaPkg::encAdds, 5'd5, 5'd2, 5'd6, 6'd0);
    progMem[4] = iForm(legIsaPkg::encAddi, zr, zr, 12'd7);
    // x31 must still read zero here
    progMem[5] = rForm(legIsaPkg::encAdd, 5'd7, zr, zr, 6'd0);
    progMem[6] = iForm(legIsaPkg::encOrri, 5'd8, zr, 12'habc);
    progMem[7] = rForm(legIsaPkg::encLsl, 5'd9, 5'd8, 5'd0, 6'd60);
    foreach (progMem[i]) begin
      if (i >= directedWords) progMem[i] = randomWord();
    end
  endtask

  task automatic buildExpected();
    logic [xlen-1:0] regsModel [32];
    logic [3:0] flagsModel;
    logic [4:0] rd;
    logic [xlen-1:0] data;
    logic [3:0] flagsNew;
    logic retires;
    regsModel = '{default: '0};
    flagsModel = '0;
    foreach (progMem[i]) begin
      retires = refExec(progMem[i], regsModel, flagsModel, rd, data, flagsNew);
      if (retires) begin
        expRd.push_back(rd);
        expData.push_back(data);
        expFlags.push_back(flagsNew);
        if (rd != zr) regsModel[rd] = data;
        flagsModel = flagsNew;
      end
    end
    expCount = expRd.size();
  endtask

  // ibus follows iaddr on the falling edge
  initial begin : ibusDriver
    ibus = '0;
    forever begin
      @(negedge clk);
      ibus = fetchWord(iaddr);
    end
  end

  // pc only ever steps by one word
  always @(negedge clk) begin
    if (rstN && iaddr != lastIaddr) begin
      checkCount++;
      assert (iaddr == lastIaddr + 64'd4) else begin
        errorCount++;
        $display("[FAIL] iaddr: got %h expected %h", iaddr, lastIaddr + 64'd4);
      end
    end
    lastIaddr = iaddr;
  end

  // compare each retirement against the model queue
  always @(negedge clk) begin
    if (rstN && retireReq && !prevReq) begin
      retireCount++;
      assert (expRd.size() > 0) else begin
        errorCount++;
        $display("retirement of rd %0d seen with no instruction left to retire", retireRd);
      end
      if (expRd.size() > 0) begin
        checkCount++;
        assert (retireRd == expRd[0]) else begin
          errorCount++;
          $display("[FAIL] retireRd: got %h expected %h", retireRd, expRd[0]);
        end
        assert (retireData == expData[0]) else begin
          errorCount++;
          $display("[FAIL] retireData: got %h expected %h", retireData, expData[0]);
        end
        assert (retireFlags == expFlags[0]) else begin
          errorCount++;
          $display("[FAIL] retireFlags: got %h expected %h", retireFlags, expFlags[0]);
        end
        void'(expRd.pop_front());
        void'(expData.pop_front());
        void'(expFlags.pop_front());
      end
    end else if (rstN) begin
      // flags move only together with a retirement
      assert (retireFlags == prevFlags) else begin
        errorCount++;
        $display("[FAIL] retireFlags: got %h expected %h", retireFlags, prevFlags);
      end
    end
    prevReq = retireReq;
    prevFlags = retireFlags;
  end

  // retire ack with random delay, first retirement held long
  initial begin : ackDriver
    int waitCycles;
    int delay;
    logic [xlen-1:0] heldAddr;
    retireAck = 1'b0;
    @(negedge clk);
    for (int k = 0; k < expCount && !hung; k++) begin
      waitCycles = 0;
      while (!retireReq && waitCycles < waitLimit) begin
        @(negedge clk);
        waitCycles++;
      end
      if (!retireReq) begin
        errorCount++;
        hung = 1'b1;
        $display("timeout waiting for retire request number %0d", k);
      end else begin
        if (k == 0) begin
          // queue fills behind the held word, fetch has to stop
          repeat (stallCycles - stallWindow) @(negedge clk);
          heldAddr = iaddr;
          repeat (stallWindow) @(negedge clk);
          checkCount++;
          assert (iaddr == heldAddr) else begin
            errorCount++;
            $display("[FAIL] iaddr: got %h expected %h", iaddr, heldAddr);
          end
        end else begin
          delay = (lcgNext() >> 16) % 6;
          repeat (delay) @(negedge clk);
        end
        retireAck = 1'b1;
        waitCycles = 0;
        while (retireReq && waitCycles < waitLimit) begin
          @(negedge clk);
          waitCycles++;
        end
        if (retireReq) begin
          errorCount++;
          hung = 1'b1;
          $display("timeout: retire request stayed high after ack");
        end
        retireAck = 1'b0;
      end
    end
  end

  initial begin : mainSeq
    int cycles;
    clk = 1'b0;
    rstN = 1'b0;
    lcgState = lcgSeed;
    buildProgram();
    buildExpected();
    repeat (4) @(posedge clk);
    @(negedge clk);
    checkCount++;
    assert (iaddr == '0) else begin
      errorCount++;
      $display("[FAIL] iaddr: got %h expected %h", iaddr, 64'h0);
    end
    assert (!retireReq) else begin
      errorCount++;
      $display("[FAIL] retireReq: got %h expected %h", retireReq, 1'b0);
    end
    rstN = 1'b1;
    cycles = 0;
    while (retireCount < expCount && !hung && cycles < runLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (retireCount < expCount && !hung) begin
      errorCount++;
      $display("timeout: only %0d of %0d retirements arrived", retireCount, expCount);
    end
    // nothing more may retire once the program has drained
    repeat (drainCycles) @(negedge clk);
    assert (expRd.size() == 0) else begin
      errorCount++;
      $display("%0d expected retirements never arrived", expRd.size());
    end
    $display("retired %0d of %0d, checks %0d, errors %0d",
             retireCount, expCount, checkCount, errorCount);
    if (errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: legCore.f
verilog/legIsaPkg.sv
verilog/legCorePkg.sv
verilog/instrLink.sv
verilog/fetchDecode.sv
verilog/instrQueue.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/legCore.sv
bench/legCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the legCore testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module legCoreTb -f legCore.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut="$(./obj_dir/VlegCoreTb)"
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx -- ">>> PASS"; then
  exit 0
fi
exit 1
